// File: irq_cmd_pkg.sv
`default_nettype none

package irq_cmd_pkg;

    //////////////////////////////////////////////////
    // Source sizing, fixed by the bus protocol
    //////////////////////////////////////////////////

    localparam int NUM_SOURCES = 8;                 // Interrupt request lines
    localparam int ID_W        = 3;                 // Bits of a source number

    typedef logic [ID_W-1:0] source_id_t;           // One source number

    //////////////////////////////////////////////////
    // Command encodings and command FSM
    //////////////////////////////////////////////////

    // Mode command codes on intr_mode
    typedef enum logic [1:0] {
        MODE_NONE = 2'b00,                          // No command yet
        MODE_POLL = 2'b01,                          // Fixed ascending order
        MODE_PRIO = 2'b10,                          // Order from the priority table
        MODE_BAD  = 2'b11                           // Not a valid command
    } mode_e;

    typedef enum logic [1:0] {
        CMD_RESET,                                  // Clear and restart
        CMD_WAIT,                                   // Wait for a mode command
        CMD_CONFIRM,                                // Second look at the command
        CMD_RUN                                     // Controller active
    } cmd_state_e;

    // Entry 0 is the highest priority, in the lowest bits
    typedef source_id_t [NUM_SOURCES-1:0] prio_table_t;

    typedef struct packed {
        logic  run;                                 // Set once the mode is confirmed
        mode_e mode;                                // Confirmed mode
    } run_cfg_t;

endpackage

`default_nettype wire

// File: irq_bus_pkg.sv
`default_nettype none

package irq_bus_pkg;

    import irq_cmd_pkg::*;

    //////////////////////////////////////////////////
    // Processor bus words
    //////////////////////////////////////////////////

    // Condition codes in the upper five bits of a bus word
    typedef enum logic [4:0] {
        CODE_POLL_ID   = 5'b01011,                  // Id sent, polling mode
        CODE_PRIO_ID   = 5'b10011,                  // Id sent, priority mode
        CODE_POLL_DONE = 5'b10100,                  // Service done, polling mode
        CODE_PRIO_DONE = 5'b01100                   // Service done, priority mode
    } bus_code_e;

    typedef struct packed {
        bus_code_e  code;                           // Bits 7:3
        source_id_t id;                             // Bits 2:0
    } bus_word_t;

    // Selector result handed to the handshake side
    typedef struct packed {
        logic       valid;                          // A requesting source was found
        source_id_t id;                             // Which one
    } grant_t;

    typedef enum logic [1:0] {
        PH_SCAN,                                    // Looking for a grant
        PH_WAIT_ACK,                                // intr_out high, wait for intr_in low
        PH_WAIT_ADDR_ACK,                           // Id on the bus, wait for its ack
        PH_WAIT_DONE                                // Wait for the completion word
    } phase_e;

endpackage

`default_nettype wire

// File: irq_cmd_capture.sv
`timescale 1ns/10ps
`default_nettype none

module irq_cmd_capture
    import irq_cmd_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_in,
    input  mode_e       intr_mode,                  // Mode command from the processor
    input  prio_table_t priorities_table,           // Table, sampled with MODE_PRIO
    output run_cfg_t    run_cfg,                    // Run flag and confirmed mode
    output prio_table_t prio_table                  // Latched table
);

    cmd_state_e  state_q;
    mode_e       mode_q;                            // Mode seen in CMD_WAIT
    prio_table_t table_q;

    //////////////////////////////////////////////////
    // Command FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state_q <= CMD_RESET;
            mode_q  <= MODE_NONE;
            table_q <= '0;
        end else begin
            case (state_q)
                CMD_RESET: begin
                    mode_q  <= MODE_NONE;           // Forget any earlier command
                    table_q <= '0;
                    state_q <= CMD_WAIT;
                end

                // Only the two valid modes move on
                CMD_WAIT: begin
                    case (intr_mode)
                        MODE_POLL: begin
                            mode_q  <= MODE_POLL;
                            state_q <= CMD_CONFIRM;
                        end
                        MODE_PRIO: begin
                            mode_q  <= MODE_PRIO;
                            table_q <= priorities_table;    // Same edge as the command
                            state_q <= CMD_CONFIRM;
                        end
                        default: begin
                            state_q <= CMD_WAIT;    // Keep waiting
                        end
                    endcase
                end

                // Command must still be there one cycle later
                CMD_CONFIRM: begin
                    if (intr_mode == mode_q) begin
                        state_q <= CMD_RUN;
                    end else begin
                        state_q <= CMD_RESET;       // Changed or dropped
                    end
                end

                CMD_RUN: begin
                    state_q <= CMD_RUN;             // Only reset leaves run
                end

                default: begin
                    state_q <= CMD_RESET;
                end
            endcase
        end
    end

    // Run flag rises the cycle after confirmation
    assign run_cfg.run  = (state_q == CMD_RUN);
    assign run_cfg.mode = mode_q;
    assign prio_table   = table_q;

endmodule

`default_nettype wire

// File: irq_source_select.sv
`timescale 1ns/10ps
`default_nettype none

module irq_source_select
    import irq_cmd_pkg::*, irq_bus_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic [NUM_SOURCES-1:0] intr_rq,     // Request lines
    input  run_cfg_t               run_cfg,
    input  prio_table_t            prio_table,
    input  logic                   scan_idle,   // Handshake is free to take a grant
    output grant_t                 grant
);

    source_id_t poll_idx_q;                     // Source checked in polling mode
    logic       poll_mode;
    logic       poll_step;
    logic       prio_hit;
    source_id_t prio_id;

    //////////////////////////////////////////////////
    // Polling index
    //////////////////////////////////////////////////

    assign poll_mode = run_cfg.run && (run_cfg.mode == MODE_POLL);

    // Advance only while scanning and the current source is quiet
    assign poll_step = poll_mode && scan_idle && !intr_rq[poll_idx_q];

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            poll_idx_q <= '0;
        end else if (!run_cfg.run) begin
            poll_idx_q <= '0;                   // Start at source 0 on entering run
        end else if (poll_step) begin
            poll_idx_q <= source_id_t'(poll_idx_q + 1'b1);  // Wraps 7 to 0
        end
        // On a hit the index holds, same source checked first after service
    end

    //////////////////////////////////////////////////
    // Priority search
    //////////////////////////////////////////////////

    // Walk from the lowest priority up so entry 0 has the last word
    always_comb begin
        prio_hit = 1'b0;
        prio_id  = '0;
        for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
            if (intr_rq[prio_table[i]]) begin
                prio_hit = 1'b1;
                prio_id  = prio_table[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Grant mux
    //////////////////////////////////////////////////

    always_comb begin
        grant = '0;
        if (run_cfg.run) begin
            case (run_cfg.mode)
                MODE_POLL: begin
                    grant.valid = intr_rq[poll_idx_q];  // One source per cycle
                    grant.id    = poll_idx_q;
                end
                MODE_PRIO: begin
                    grant.valid = prio_hit;
                    grant.id    = prio_id;
                end
                default: begin
                    grant = '0;                 // Never confirmed, no grant
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: irq_handshake.sv
`timescale 1ns/10ps
`default_nettype none

module irq_handshake
    import irq_cmd_pkg::*, irq_bus_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  run_cfg_t  run_cfg,                  // Mode picks the code words
    input  grant_t    grant,
    input  logic      intr_in,                  // Processor ack, active low
    input  bus_word_t intr_ack_bus,             // Completion word from the processor
    output logic      scan_idle,
    output logic      intr_out,
    output bus_word_t intr_bus
);

    phase_e     phase_q;
    source_id_t id_q;                           // Source under service
    bus_code_e  id_code;
    bus_code_e  done_code;
    bus_word_t  id_word;
    bus_word_t  done_word;
    logic       done_ok;

    //////////////////////////////////////////////////
    // Code words for the running mode
    //////////////////////////////////////////////////

    always_comb begin
        if (run_cfg.mode == MODE_PRIO) begin
            id_code   = CODE_PRIO_ID;
            done_code = CODE_PRIO_DONE;
        end else begin
            id_code   = CODE_POLL_ID;
            done_code = CODE_POLL_DONE;
        end
        id_word   = '{code: id_code, id: id_q};
        done_word = '{code: done_code, id: id_q};
    end

    // Code and id must both match, anything else is ignored
    assign done_ok = !intr_in && (intr_ack_bus == done_word);

    //////////////////////////////////////////////////
    // Service phase FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            phase_q  <= PH_SCAN;
            intr_out <= 1'b0;
            intr_bus <= '0;
        end else begin
            case (phase_q)
                PH_SCAN: begin
                    if (grant.valid) begin
                        intr_out <= 1'b1;       // Raise the interrupt
                        phase_q  <= PH_WAIT_ACK;
                    end
                end
                PH_WAIT_ACK: begin
                    if (!intr_in) begin
                        intr_out <= 1'b0;       // Ack seen, drop the line
                        intr_bus <= id_word;    // Tell which source
                        phase_q  <= PH_WAIT_ADDR_ACK;
                    end
                end
                PH_WAIT_ADDR_ACK: begin
                    if (!intr_in) phase_q <= PH_WAIT_DONE;
                end
                PH_WAIT_DONE: begin
                    if (done_ok) phase_q <= PH_SCAN;    // Back to scanning
                end
                default: begin
                    phase_q <= PH_SCAN;
                end
            endcase
        end
    end

    // Id of the granted source, taken when the interrupt is raised
    always_ff @(posedge clk_in) begin
        if (phase_q == PH_SCAN && grant.valid) begin
            id_q <= grant.id;
        end
    end

    assign scan_idle = (phase_q == PH_SCAN);    // Selector freezes while low

endmodule

`default_nettype wire

// File: irq_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl_top
    import irq_cmd_pkg::*, irq_bus_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic [NUM_SOURCES-1:0] intr_rq,          // Request lines
    input  mode_e                  intr_mode,        // Mode command
    input  prio_table_t            priorities_table, // Eight 3-bit ids
    input  logic                   intr_in,          // Processor ack, active low
    input  bus_word_t              intr_ack_bus,     // Completion word
    output logic                   intr_out,         // Interrupt to the processor
    output bus_word_t              intr_bus          // Id word to the processor
);

    run_cfg_t    run_cfg;
    prio_table_t prio_table;
    grant_t      grant;
    logic        scan_idle;

    // Command side
    irq_cmd_capture u_cmd (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .intr_mode        (intr_mode),
        .priorities_table (priorities_table),
        .run_cfg          (run_cfg),
        .prio_table       (prio_table)
    );

    // Source selection, polling or priority
    irq_source_select u_sel (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .intr_rq    (intr_rq),
        .run_cfg    (run_cfg),
        .prio_table (prio_table),
        .scan_idle  (scan_idle),
        .grant      (grant)
    );

    // Processor handshake
    irq_handshake u_hs (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .run_cfg      (run_cfg),
        .grant        (grant),
        .intr_in      (intr_in),
        .intr_ack_bus (intr_ack_bus),
        .scan_idle    (scan_idle),
        .intr_out     (intr_out),
        .intr_bus     (intr_bus)
    );

endmodule

`default_nettype wire

// File: irq_ctrl_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl_asserts
    import irq_bus_pkg::*;
(
    input logic      clk_in,
    input logic      rst_in,
    input logic      intr_in,                   // Processor ack, active low
    input logic      intr_out,
    input bus_word_t intr_bus,
    input phase_e    phase                      // Service phase of the handshake
);

    //////////////////////////////////////////////////
    // Handshake rules
    //////////////////////////////////////////////////

    // Interrupt line held until the processor acks
    a_hold_intr: assert property (@(posedge clk_in) disable iff (rst_in)
        (intr_out && intr_in) |=> intr_out)
        else $error("intr_out dropped without an acknowledge");

    a_bus_on_ack: assert property (@(posedge clk_in) disable iff (rst_in)
        $changed(intr_bus) |-> $fell(intr_out))  // Id word loaded with the ack
        else $error("intr_bus changed outside an acknowledge");

    a_intr_phase: assert property (@(posedge clk_in) disable iff (rst_in)
        intr_out |-> (phase == PH_WAIT_ACK))
        else $error("intr_out high outside PH_WAIT_ACK");

endmodule

bind irq_handshake irq_ctrl_asserts u_asserts (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .intr_in  (intr_in),
    .intr_out (intr_out),
    .intr_bus (intr_bus),
    .phase    (phase_q)
);

`default_nettype wire

// File: irq_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl_tb
    import irq_cmd_pkg::*, irq_bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 600;            // Six tests of about 80 cycles plus margin

    logic                   clk_in = 1'b0;
    logic                   rst_in;
    logic [NUM_SOURCES-1:0] intr_rq;
    mode_e                  intr_mode;
    prio_table_t            priorities_table;
    logic                   intr_in;                // Active low ack
    bus_word_t              intr_ack_bus;
    logic                   intr_out;
    bus_word_t              intr_bus;

    int     cycles = 0;                             // Free running cycle count
    int     errors = 0;
    integer seed   = 81;                            // Seed for $random

    irq_ctrl_top u_dut (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .intr_rq          (intr_rq),
        .intr_mode        (intr_mode),
        .priorities_table (priorities_table),
        .intr_in          (intr_in),
        .intr_ack_bus     (intr_ack_bus),
        .intr_out         (intr_out),
        .intr_bus         (intr_bus)
    );

    always #10 clk_in = ~clk_in;                    // 20 ns period

    //////////////////////////////////////////////////
    // Reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic fail_now(input string what);
        errors++;
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    always @(posedge clk_in) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) fail_now("Run did not finish within the cycle limit");
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_now($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
        if (got !== exp) fail_now($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    function automatic bus_word_t make_word(input bus_code_e code, input source_id_t id);
        return '{code: code, id: id};
    endfunction

    // First table entry whose source requests, entry 0 first
    function automatic source_id_t first_in_table(input prio_table_t tbl,
                                                  input logic [NUM_SOURCES-1:0] rq);
        source_id_t found;
        logic       hit;
        found = '0;
        hit   = 1'b0;
        for (int i = 0; i < NUM_SOURCES; i++) begin
            if (!hit && rq[tbl[i]]) begin
                hit   = 1'b1;
                found = tbl[i];
            end
        end
        return found;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_in);
            #2;                                     // Drive and sample point
        end
    endtask

    task automatic apply_reset();
        rst_in       = 1'b1;
        intr_rq      = '0;
        intr_mode    = MODE_NONE;
        intr_in      = 1'b1;
        intr_ack_bus = '0;
        idle(4);
        rst_in       = 1'b0;
    endtask

    // Command held from reset release, confirmed two edges after CMD_WAIT
    task automatic start_mode(input mode_e mode, input prio_table_t tbl);
        apply_reset();
        priorities_table = tbl;
        intr_mode        = mode;
    endtask

    task automatic wait_intr(input int limit);
        int n;
        n = 0;
        while (intr_out !== 1'b1) begin
            if (n >= limit) fail_now($sformatf("intr_out did not rise within %0d cycles", limit));
            idle(1);
            n++;
        end
    endtask

    task automatic pulse_ack();
        intr_in = 1'b0;
        idle(1);
        intr_in = 1'b1;
    endtask

    task automatic send_done(input bus_word_t word);
        intr_ack_bus = word;
        intr_in      = 1'b0;                        // Third low, with the word
        idle(1);
        intr_in      = 1'b1;
        intr_ack_bus = '0;
    endtask

    // Interrupt, ack with id check, then address ack
    task automatic take_irq(input bus_word_t exp);
        wait_intr(40);
        idle(2);                                    // Line must hold until the ack
        check_bit("intr_out", intr_out, 1'b1);
        pulse_ack();
        check_bit("intr_out", intr_out, 1'b0);
        check_word("intr_bus", intr_bus, exp);
        idle(1);
        pulse_ack();                                // Id acknowledged
        idle(1);
    endtask

    task automatic hold_quiet(input int n, input bus_word_t exp_bus);
        repeat (n) begin
            idle(1);
            check_bit("intr_out", intr_out, 1'b0);
            check_word("intr_bus", intr_bus, exp_bus); // Bus keeps its last word
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        start_mode(MODE_NONE, '0);
        intr_rq = '1;                               // Requests without a mode
        check_word("intr_bus", intr_bus, '0);
        hold_quiet(20, '0);
        intr_mode = MODE_BAD;
        hold_quiet(20, '0);
    endtask

    task automatic test_poll_service();
        start_mode(MODE_POLL, '0);
        intr_rq = 8'h20;                            // Source 5 only
        take_irq(make_word(CODE_POLL_ID, 3'd5));
        send_done(make_word(CODE_POLL_DONE, 3'd5));
        intr_rq = '0;
        hold_quiet(20, make_word(CODE_POLL_ID, 3'd5));
    endtask

    task automatic test_poll_order();
        start_mode(MODE_POLL, '0);
        intr_rq = 8'h44;                            // Sources 2 and 6
        take_irq(make_word(CODE_POLL_ID, 3'd2));    // Index ascends from 0
        send_done(make_word(CODE_POLL_DONE, 3'd2));
        intr_rq = 8'h40;
        take_irq(make_word(CODE_POLL_ID, 3'd6));
        send_done(make_word(CODE_POLL_DONE, 3'd6));
        intr_rq = '0;
    endtask

    task automatic test_wrong_done();
        start_mode(MODE_POLL, '0);
        intr_rq = 8'h18;                            // Source 4 keeps requesting
        take_irq(make_word(CODE_POLL_ID, 3'd3));
        send_done(make_word(CODE_PRIO_DONE, 3'd3)); // Wrong code
        idle(1);
        send_done(make_word(CODE_POLL_DONE, 3'd4)); // Wrong id
        hold_quiet(20, make_word(CODE_POLL_ID, 3'd3));
        send_done(make_word(CODE_POLL_DONE, 3'd3));
        intr_rq = 8'h10;
        take_irq(make_word(CODE_POLL_ID, 3'd4));
        send_done(make_word(CODE_POLL_DONE, 3'd4));
        intr_rq = '0;
    endtask

    task automatic test_prio_select();
        prio_table_t      tbl;
        logic [31:0]      rnd;
        logic [NUM_SOURCES-1:0] rq;
        source_id_t       exp;
        tbl = {3'd6, 3'd5, 3'd4, 3'd2, 3'd0, 3'd1, 3'd7, 3'd3};  // Entry 0 is 3
        start_mode(MODE_PRIO, tbl);
        intr_rq = 8'h82;                            // Sources 1 and 7
        take_irq(make_word(CODE_PRIO_ID, 3'd7));
        send_done(make_word(CODE_PRIO_DONE, 3'd7));
        intr_rq = 8'h02;
        take_irq(make_word(CODE_PRIO_ID, 3'd1));
        send_done(make_word(CODE_PRIO_DONE, 3'd1));
        intr_rq = '0;
        repeat (3) begin
            rnd = $random(seed);
            rq  = rnd[NUM_SOURCES-1:0];
            if (rq == '0) rq = 8'h01;               // Need at least one request
            exp = first_in_table(tbl, rq);
            intr_rq = rq;
            take_irq(make_word(CODE_PRIO_ID, exp));
            send_done(make_word(CODE_PRIO_DONE, exp));
            intr_rq = '0;
        end
    endtask

    task automatic test_mode_change();
        apply_reset();
        idle(1);                                    // Now in CMD_WAIT
        intr_mode = MODE_POLL;
        idle(1);                                    // Command taken, confirm next
        intr_mode = MODE_BAD;
        intr_rq   = 8'h01;
        hold_quiet(20, '0);
        intr_mode = MODE_POLL;                      // Fresh command from waiting
        take_irq(make_word(CODE_POLL_ID, 3'd0));
        send_done(make_word(CODE_POLL_DONE, 3'd0));
        intr_rq = '0;
    endtask

    initial begin
        rst_in           = 1'b1;
        intr_rq          = '0;
        intr_mode        = MODE_NONE;
        priorities_table = '0;
        intr_in          = 1'b1;
        intr_ack_bus     = '0;
        test_reset_state();
        test_poll_service();
        test_poll_order();
        test_wrong_done();
        test_prio_select();
        test_mode_change();
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: irq_ctrl_top.f
irq_cmd_pkg.sv
irq_bus_pkg.sv
irq_cmd_capture.sv
irq_source_select.sv
irq_handshake.sv
irq_ctrl_top.sv
irq_ctrl_asserts.sv
irq_ctrl_tb.sv

// File: Makefile
# Verilator build for the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= irq_ctrl_tb
FILELIST  ?= irq_ctrl_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert -j 0
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
